//--- compile.f
+incdir+common
common/uart_pkg.sv
logic/tx_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
logic/uart_link.sv
verification/uart_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UART link testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module uart_link_tb \
    --Mdir obj_dir \
    -o uart_link_sim

./obj_dir/uart_link_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- verification/uart_link_tb.sv
// UART link testbench
// Writes host bytes and decodes the tx line, overruns the FIFO with a burst,
// then drives rx frames with good and corrupted parity and stop bits.

`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_link_tb import uart_pkg::*; ();

    localparam int SINGLE_N   = 4;  // Bytes written one at a time
    localparam int BURST_N    = 16; // Back-to-back writes exceeding the FIFO depth
    localparam int TX_N       = SINGLE_N + BURST_N;
    localparam int RX_N       = 8;
    localparam int FILL_SLACK = 40; // Reset, idle gaps and drain waits
    localparam int TIMEOUT    = ((TX_N + RX_N) * 11 + FILL_SLACK) * 2;

    typedef struct packed {
        uart_byte_t data;
        logic       bad_par;  // Send the inverted parity bit
        logic       bad_stop; // Send a 0 stop bit
    } rx_case_t;

    logic       baud_clk;
    logic       rst;
    logic       wr_en;
    uart_byte_t wr_data;
    logic       rx;
    logic       full;
    logic       tx;
    logic       tx_busy;
    rx_result_t rx_result;
    logic       rx_valid;

    uart_byte_t  tx_table [TX_N];
    rx_case_t    rx_table [RX_N];
    uart_byte_t  exp_q [$];   // Bytes the FIFO should accept, in order
    uart_byte_t  got_q [$];   // Bytes decoded from tx
    rx_result_t  rx_q [$];    // Results seen with rx_valid
    logic [31:0] lcg_state;
    int          cycles;
    int          i;
    int          mon_idx;
    uart_byte_t  mon_byte;
    int          model_count; // Expected FIFO occupancy
    int          tx_wait;     // Edges until the transmitter can pop again
    logic        can_pop;
    logic        accept;

    uart_link uut (
        .baud_clk  (baud_clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .rx        (rx),
        .full      (full),
        .tx        (tx),
        .tx_busy   (tx_busy),
        .rx_result (rx_result),
        .rx_valid  (rx_valid)
    );

    always #5 baud_clk = ~baud_clk; // 10 ns bit time

    function automatic uart_byte_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16]; // Middle bits spread better than the low ones
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic write_byte(input uart_byte_t b);
        check_value("full", 32'(full), 32'd0);
        wr_en   = 1'b1;
        wr_data = b;
        exp_q.push_back(b);
        @(negedge baud_clk);
        wr_en   = 1'b0;
    endtask

    task automatic send_frame(input rx_case_t c);
        int   k;
        logic par;
        par = (^c.data) ^ (`UART_PARITY_ODD != 0) ^ c.bad_par;
        rx  = 1'b0; // Start bit
        @(negedge baud_clk);
        for (k = 0; k < 8; k++) begin
            rx = c.data[k]; // LSB first
            @(negedge baud_clk);
        end
        rx = par;
        @(negedge baud_clk);
        rx = !c.bad_stop;
        @(negedge baud_clk);
        rx = 1'b1; // Back to idle
    endtask

    // Frame decoder on tx sampling mid-bit
    always begin
        @(negedge baud_clk);
        if (!rst && tx === 1'b0) begin
            check_value("tx_busy", 32'(tx_busy), 32'd1); // Start bit
            for (mon_idx = 0; mon_idx < 8; mon_idx++) begin
                @(negedge baud_clk);
                mon_byte[mon_idx] = tx;
                check_value("tx_busy", 32'(tx_busy), 32'd1);
            end
            @(negedge baud_clk);
            check_value("tx parity", 32'(tx),
                        32'((^mon_byte) ^ (`UART_PARITY_ODD != 0)));
            check_value("tx_busy", 32'(tx_busy), 32'd1);
            @(negedge baud_clk);
            check_value("tx stop", 32'(tx), 32'd1);
            check_value("tx_busy", 32'(tx_busy), 32'd1);
            got_q.push_back(mon_byte);
            @(negedge baud_clk);
            check_value("tx_busy", 32'(tx_busy), 32'd0); // Drops after stop
        end
    end

    always @(negedge baud_clk) begin
        if (!rst && rx_valid) begin
            rx_q.push_back(rx_result);
        end
    end

    always @(posedge baud_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run passed %0d cycles without finishing", TIMEOUT);
            $display("test failed");
            $fatal(1);
        end
    end

    initial begin
        baud_clk  = 1'b0;
        rst       = 1'b1;
        wr_en     = 1'b0;
        wr_data   = '0;
        rx        = 1'b1;
        cycles    = 0;
        lcg_state = 32'd55173;
        tx_table[0] = 8'h55; // Alternating bits
        tx_table[1] = 8'hA5;
        tx_table[2] = 8'h00; // Even parity 0
        tx_table[3] = 8'hFF;
        tx_table[4] = 8'h80;
        for (i = 5; i < TX_N; i++) begin
            tx_table[i] = next_rand();
        end
        rx_table[0] = {8'h5A, 2'b00};
        rx_table[1] = {8'h00, 2'b00};
        rx_table[2] = {8'hFF, 2'b00};
        rx_table[3] = {8'h3C, 2'b10}; // Bad parity
        rx_table[4] = {8'h81, 2'b01}; // Bad stop
        rx_table[5] = {8'hC7, 2'b11}; // Both
        rx_table[6] = {8'h12, 2'b00};
        rx_table[7] = {8'hE4, 2'b10};
        repeat (2) @(negedge baud_clk);
        rst = 1'b0;

        check_value("tx", 32'(tx), 32'd1);
        check_value("tx_busy", 32'(tx_busy), 32'd0);
        check_value("rx_valid", 32'(rx_valid), 32'd0);
        check_value("full", 32'(full), 32'd0);

        // One byte per frame and wait for each to leave
        for (i = 0; i < SINGLE_N; i++) begin
            write_byte(tx_table[i]);
            while (got_q.size() < exp_q.size()) @(negedge baud_clk);
            while (tx_busy) @(negedge baud_clk);
        end

        // Burst from an idle transmitter and an empty FIFO
        model_count = 0;
        tx_wait     = 0;
        for (i = 0; i < BURST_N; i++) begin
            check_value("full", 32'(full), 32'(model_count == `UART_FIFO_DEPTH));
            wr_en   = 1'b1;
            wr_data = tx_table[SINGLE_N + i];
            can_pop = (tx_wait == 0) && (model_count > 0);
            accept  = (model_count < `UART_FIFO_DEPTH);
            if (accept) begin
                exp_q.push_back(tx_table[SINGLE_N + i]);
            end
            if (tx_wait > 0) begin
                tx_wait--;
            end else if (can_pop) begin
                tx_wait = 11; // Pop edge to the edge that ends the stop bit
            end
            model_count = model_count + int'(accept) - int'(can_pop);
            @(negedge baud_clk);
        end
        wr_en = 1'b0;

        while (got_q.size() < exp_q.size()) @(negedge baud_clk);
        repeat (30) @(negedge baud_clk); // Nothing extra may follow
        check_value("tx frame count", 32'(got_q.size()), 32'(exp_q.size()));
        for (i = 0; i < exp_q.size(); i++) begin
            check_value("tx byte", 32'(got_q[i]), 32'(exp_q[i]));
        end

        for (i = 0; i < RX_N; i++) begin
            send_frame(rx_table[i]);
            while (rx_q.size() < i + 1) @(negedge baud_clk);
            repeat (3) @(negedge baud_clk);
            check_value("rx_valid pulses", 32'(rx_q.size()), 32'(i + 1));
            check_value("rx_result.data", 32'(rx_q[i].data), 32'(rx_table[i].data));
            check_value("rx_result.parity_err", 32'(rx_q[i].parity_err),
                        32'(rx_table[i].bad_par));
            check_value("rx_result.frame_err", 32'(rx_q[i].frame_err),
                        32'(rx_table[i].bad_stop));
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/uart_link.sv
// UART link top level
// Host bytes go through the transmit FIFO into the serializer on tx.
// The receiver on rx reports bytes straight to the ports.

`timescale 1ns/1ps
`default_nettype none

module uart_link import uart_pkg::*; (
    input  wire logic       baud_clk,
    input  wire logic       rst,
    input  wire logic       wr_en,     // Host write strobe
    input  wire uart_byte_t wr_data,   // Host byte
    input  wire logic       rx,        // Serial input
    output logic            full,      // FIFO cannot accept a write
    output logic            tx,        // Serial output
    output logic            tx_busy,   // Frame in progress
    output rx_result_t      rx_result, // Received byte and flags
    output logic            rx_valid   // Received byte strobe
);

    uart_byte_t fifo_data; // FIFO head to serializer
    logic       empty;
    logic       pop;

    tx_fifo u_tx_fifo (
        .baud_clk  (baud_clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .pop       (pop),
        .fifo_data (fifo_data),
        .empty     (empty),
        .full      (full)
    );

    uart_tx u_uart_tx (
        .baud_clk  (baud_clk),
        .rst       (rst),
        .fifo_data (fifo_data),
        .empty     (empty),
        .pop       (pop),
        .tx        (tx),
        .tx_busy   (tx_busy)
    );

    uart_rx u_uart_rx (
        .baud_clk  (baud_clk),
        .rst       (rst),
        .rx        (rx),
        .rx_result (rx_result),
        .rx_valid  (rx_valid)
    );

endmodule

`default_nettype wire

//--- uart_rx/uart_rx.sv
// UART frame deserializer
// Samples rx once per baud_clk, detects the start bit, shifts in eight data
// bits LSB first and checks parity and stop. Reports each byte with a
// one-cycle rx_valid pulse on the stop-bit edge.

`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_rx import uart_pkg::*; (
    input  wire logic baud_clk,
    input  wire logic rst,
    input  wire logic rx,        // Serial line, aligned to baud_clk
    output rx_result_t rx_result, // Last received byte and error flags
    output logic       rx_valid   // One-cycle pulse per frame
);

    rx_state_t  state;
    uart_byte_t rx_shift;   // Incoming data filled from the top
    logic [2:0] bit_idx;    // Data bits received so far
    logic       rx_par_bit; // Sampled parity bit
    logic       exp_parity; // Parity computed from the data

    assign exp_parity = (^rx_shift) ^ (`UART_PARITY_ODD != 0);

    // Data capture in each FSM state
    always_ff @(posedge baud_clk) begin
        if (state == RX_DATA) begin
            rx_shift <= {rx, rx_shift[7:1]}; // LSB arrives first
        end
        if (state == RX_PARITY) begin
            rx_par_bit <= rx;
        end
        if (state == RX_STOP) begin
            rx_result.data       <= rx_shift;
            rx_result.parity_err <= (rx_par_bit != exp_parity);
            rx_result.frame_err  <= !rx; // Stop must read 1
        end
    end

    always_ff @(posedge baud_clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0; // Pulse by default
            case (state)
                RX_IDLE: begin
                    bit_idx <= '0;
                    if (!rx) begin
                        state <= RX_DATA; // Start bit seen
                    end
                end
                RX_DATA: begin
                    if (bit_idx == 3'd7) begin
                        state <= RX_PARITY;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                RX_PARITY: begin
                    state <= RX_STOP;
                end
                RX_STOP: begin
                    rx_valid <= 1'b1; // Result loads on this edge
                    state    <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Frames are at least eleven bits apart, so no back-to-back pulses
    a_valid_single: assert property (@(posedge baud_clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- uart_tx/uart_tx.sv
// UART frame serializer
// Pops one byte from the transmit FIFO when idle and sends start, eight data
// bits LSB first, parity and stop on tx, one bit per baud_clk cycle.

`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tx import uart_pkg::*; (
    input  wire logic       baud_clk,
    input  wire logic       rst,
    input  wire uart_byte_t fifo_data, // Oldest FIFO byte
    input  wire logic       empty,     // FIFO has nothing to send
    output logic            pop,       // One-cycle consume strobe
    output logic            tx,        // Serial line
    output logic            tx_busy    // High from start bit through stop bit
);

    tx_state_t  state;
    uart_byte_t tx_byte;   // Latched frame payload
    logic [2:0] bit_idx;   // Data bit being sent
    logic       tx_parity; // Parity of the latched byte

    // Pop only from idle, FIFO advances on the capture edge
    assign pop = (state == TX_IDLE) && !empty;

    // XOR for even, inverted for odd
    assign tx_parity = (^tx_byte) ^ (`UART_PARITY_ODD != 0);

    always_ff @(posedge baud_clk) begin
        if (pop) begin
            tx_byte <= fifo_data; // Capture with the pop
        end
    end

    // tx is registered, so each state drives the bit that shows after its edge
    always_ff @(posedge baud_clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            bit_idx <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    tx      <= 1'b1;
                    tx_busy <= 1'b0; // Stop bit has ended
                    if (pop) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    tx      <= 1'b0; // Start bit
                    tx_busy <= 1'b1;
                    bit_idx <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA: begin
                    tx <= tx_byte[bit_idx]; // LSB first
                    if (bit_idx == 3'd7) begin
                        state <= TX_PARITY;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                TX_PARITY: begin
                    tx    <= tx_parity;
                    state <= TX_STOP;
                end
                TX_STOP: begin
                    tx    <= 1'b1; // Stop bit with busy held one more cycle
                    state <= TX_IDLE;
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Line idles high outside a frame
    a_idle_high: assert property (@(posedge baud_clk) disable iff (rst)
        !tx_busy |-> tx);

    // A pop puts the start bit on tx two edges later
    a_pop_starts_frame: assert property (@(posedge baud_clk) disable iff (rst)
        pop |-> ##2 (!tx && tx_busy));

endmodule

`default_nettype wire

//--- logic/tx_fifo.sv
// Transmit byte FIFO
// Circular buffer between the host write port and the UART transmitter.
// Push and pop may land in the same cycle; writes while full are dropped.

`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module tx_fifo import uart_pkg::*; (
    input  wire logic       baud_clk,
    input  wire logic       rst,
    input  wire logic       wr_en,     // Host write strobe
    input  wire uart_byte_t wr_data,   // Host byte
    input  wire logic       pop,       // Consume oldest byte
    output uart_byte_t      fifo_data, // Oldest byte, valid when not empty
    output logic            empty,
    output logic            full
);

    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int AW    = `UART_FIFO_AW;

    uart_byte_t      mem [DEPTH]; // Byte storage
    logic [AW-1:0]   wr_ptr;      // Next slot to write
    logic [AW-1:0]   rd_ptr;      // Oldest slot
    logic [AW:0]     count;       // Occupancy, 0..DEPTH
    logic            push;
    logic            do_pop;

    assign push      = wr_en && !full;  // Drop writes when full
    assign do_pop    = pop && !empty;
    assign empty     = (count == '0);
    assign full      = (count == (AW+1)'(DEPTH));
    assign fifo_data = mem[rd_ptr];     // Show-ahead read

    always_ff @(posedge baud_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge baud_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither, level unchanged
            endcase
        end
    end

    // Transmitter must only pop a byte that exists
    a_no_pop_when_empty: assert property (@(posedge baud_clk) disable iff (rst)
        pop |-> !empty);

    // Occupancy bounded by the storage size
    a_count_in_range: assert property (@(posedge baud_clk) disable iff (rst)
        count <= (AW+1)'(DEPTH));

endmodule

`default_nettype wire

//--- common/uart_pkg.sv
// UART link shared types
// Data byte, transmit and receive FSM states, and the receive result record

`default_nettype none

package uart_pkg;

    // One serial data byte, bit 0 goes out first
    typedef logic [7:0] uart_byte_t;

    // Transmit FSM, one state per frame section
    typedef enum logic [2:0] {
        TX_IDLE,   // Line high, waiting for FIFO data
        TX_START,  // Byte latched, start bit next
        TX_DATA,   // Eight data bits
        TX_PARITY, // Parity bit
        TX_STOP    // Stop bit
    } tx_state_t;

    // Receive FSM, start bit is detected from idle
    typedef enum logic [1:0] {
        RX_IDLE,   // Waiting for rx low
        RX_DATA,   // Shifting in data bits
        RX_PARITY, // Sampling parity bit
        RX_STOP    // Sampling stop bit
    } rx_state_t;

    // Per-byte receive report, 10 bits
    typedef struct packed {
        uart_byte_t data; // Rebuilt byte
        logic parity_err; // Parity bit mismatch
        logic frame_err;  // Stop bit read as 0
    } rx_result_t;

endpackage

`default_nettype wire

//--- common/uart_params.svh
// UART link build-time parameters
// FIFO sizing for the transmit buffer and the parity sense shared by TX and RX

`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Transmit FIFO holds this many bytes
`define UART_FIFO_DEPTH 8

// Pointer width, log2 of the depth
`define UART_FIFO_AW 3

// 0 selects even parity (XOR of data), 1 selects odd parity (inverted XOR)
`define UART_PARITY_ODD 0

`endif
